// ==== vlog.f ====
source/rdma_stack_pkg.sv
source/rdma_user_pkg.sv
source/rdma_credit_ctrl.sv
source/rdma_sq_packer.sv
source/rdma_ack_unpacker.sv
source/rdma_mem_cmd_unpacker.sv
source/rdma_cmd_adapter.sv
verification/tb_clk_gen.sv
verification/rdma_credit_chk.sv
verification/tb_rdma_cmd_adapter.sv

// ==== verification/tb_rdma_cmd_adapter.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_rdma_cmd_adapter;

  import rdma_stack_pkg::*;
  import rdma_user_pkg::*;

  localparam int NUM_ROWS       = 24;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * 6 + (3 * CREDITS_MAX + 8) + 40;
  localparam logic [31:0] SEED  = 32'h2037_c6cb;

  // One stimulus row with its expected output, both zero-extended
  typedef struct packed {
    logic [1:0]   path;
    logic [255:0] stim;
    logic [255:0] expect_word;
  } row_t;

  wire nclk;
  wire rst_n;
  wire [N_PATHS-1:0] ready_vec;
  wire [N_PATHS-1:0] valid_vec;

  logic [N_PATHS-1:0] in_valid;
  logic [N_PATHS-1:0] credit;
  user_sq_t           user_sq;
  rdma_ack_word_t     stack_ack;
  rdma_mem_cmd_u      stack_rd_cmd;
  rdma_mem_cmd_u      stack_wr_cmd;
  rdma_sq_word_t      stack_sq;
  user_ack_t          user_ack;
  mem_req_t           mem_rd_req;
  mem_req_t           mem_wr_req;

  row_t        table_rows [NUM_ROWS];
  logic [31:0] rng;
  int          errors;
  int          cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(RESET_CYCLES)) u_clk (.nclk(nclk), .rst_n(rst_n));

  rdma_cmd_adapter DUT (
    .nclk            (nclk),
    .rst_n           (rst_n),
    .user_sq         (user_sq),
    .user_sq_valid   (in_valid[PATH_SQ]),
    .user_sq_ready   (ready_vec[PATH_SQ]),
    .stack_sq        (stack_sq),
    .stack_sq_valid  (valid_vec[PATH_SQ]),
    .stack_sq_credit (credit[PATH_SQ]),
    .stack_ack       (stack_ack),
    .stack_ack_valid (in_valid[PATH_ACK]),
    .stack_ack_ready (ready_vec[PATH_ACK]),
    .user_ack        (user_ack),
    .user_ack_valid  (valid_vec[PATH_ACK]),
    .user_ack_credit (credit[PATH_ACK]),
    .stack_rd_cmd    (stack_rd_cmd),
    .stack_rd_valid  (in_valid[PATH_RD]),
    .stack_rd_ready  (ready_vec[PATH_RD]),
    .mem_rd_req      (mem_rd_req),
    .mem_rd_valid    (valid_vec[PATH_RD]),
    .mem_rd_credit   (credit[PATH_RD]),
    .stack_wr_cmd    (stack_wr_cmd),
    .stack_wr_valid  (in_valid[PATH_WR]),
    .stack_wr_ready  (ready_vec[PATH_WR]),
    .mem_wr_req      (mem_wr_req),
    .mem_wr_valid    (valid_vec[PATH_WR]),
    .mem_wr_credit   (credit[PATH_WR])
  );

  bind rdma_cmd_adapter rdma_credit_chk u_chk (
    .nclk       (nclk),
    .rst_n      (rst_n),
    .credit_cnt (u_credit.credit_cnt),
    .accept     (accept),
    .credit_ret (credit_ret),
    .out_valid  ({mem_wr_valid, mem_rd_valid, user_ack_valid, stack_sq_valid})
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_bits(output logic [255:0] v);
    for (int k = 0; k < 8; k++) begin
      rng = lcg_step(rng);
      v[k*32 +: 32] = rng;
    end
  endtask

  // Send-queue layout, every unnamed field is reserved zero
  function automatic rdma_sq_word_t expect_sq(input user_sq_t s);
    return rdma_sq_word_t'{opcode: s.req_1.opcode, pid: s.req_1.pid, vfid: s.req_1.vfid,
                           host: s.req_1.host, last: s.req_1.last, offs: s.req_1.offs,
                           vaddr_1: s.req_1.vaddr, vaddr_2: s.req_2.vaddr,
                           dest: s.req_1.dest, strm: s.req_2.strm,
                           len: RDMA_LEN_BITS'(s.req_1.len),
                           imm_offs: s.req_2.offs[SQ_IMM_OFFS_BITS-1:0],
                           imm_len: s.req_2.len, default: '0};
  endfunction

  function automatic user_ack_t expect_ack(input rdma_ack_word_t a);
    return user_ack_t'{opcode: a.opcode, remote: 1'b1, pid: a.pid, vfid: a.vfid,
                       host: a.host, dest: a.dest, strm: a.strm, rsrvd: '0, last: a.last};
  endfunction

  function automatic mem_req_t expect_mem(input rdma_mem_cmd_fields_t f);
    return mem_req_t'{opcode: f.opcode, mode: MODE_RAW, rdma: 1'b1, remote: 1'b0,
                      pid: f.pid, vfid: f.vfid, last: f.last, vaddr: f.vaddr, dest: f.dest,
                      strm: f.strm, len: f.len, actv: f.actv, host: f.host, offs: f.offs};
  endfunction

  function automatic logic [255:0] out_word(input int p);
    case (p)
      PATH_SQ:  return stack_sq;
      PATH_ACK: return user_ack;
      PATH_RD:  return mem_rd_req;
      default:  return mem_wr_req;
    endcase
  endfunction

  function automatic string out_name(input int p);
    case (p)
      PATH_SQ:  return "stack_sq";
      PATH_ACK: return "user_ack";
      PATH_RD:  return "mem_rd_req";
      default:  return "mem_wr_req";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
  endtask

  task automatic build_table();
    logic [255:0]   v;
    user_sq_t       sq;
    rdma_ack_word_t ack;
    rdma_mem_cmd_u  mc;
    for (int i = 0; i < NUM_ROWS; i++) begin
      draw_bits(v);
      table_rows[i].path = 2'(i % N_PATHS);
      case (i % N_PATHS)
        PATH_SQ: begin
          sq = v[$bits(user_sq_t)-1:0];
          table_rows[i].stim = sq;
          table_rows[i].expect_word = expect_sq(sq);
        end
        PATH_ACK: begin
          // The core leaves its reserved bits at zero
          ack = v[$bits(rdma_ack_word_t)-1:0];
          ack.rsvd_top = '0;
          ack.rsvd_qpn = '0;
          ack.rsvd_op  = '0;
          table_rows[i].stim = ack;
          table_rows[i].expect_word = expect_ack(ack);
        end
        default: begin
          mc.raw = v[RDMA_MEM_CMD_BITS-1:0];
          mc.fld.rsvd_top = '0;
          mc.fld.rsvd_qpn = '0;
          mc.fld.rsvd_op  = '0;
          table_rows[i].stim = mc.raw;
          table_rows[i].expect_word = expect_mem(mc.fld);
        end
      endcase
    end
  endtask

  task automatic apply_row(input row_t r, input int idx);
    logic [255:0] got;
    @(posedge nclk);
    case (r.path)
      PATH_SQ:  user_sq          <= r.stim[$bits(user_sq_t)-1:0];
      PATH_ACK: stack_ack        <= r.stim[$bits(rdma_ack_word_t)-1:0];
      PATH_RD:  stack_rd_cmd.raw <= r.stim[RDMA_MEM_CMD_BITS-1:0];
      default:  stack_wr_cmd.raw <= r.stim[RDMA_MEM_CMD_BITS-1:0];
    endcase
    in_valid[r.path] <= 1'b1;
    @(negedge nclk);
    while (!ready_vec[r.path]) begin
      @(negedge nclk);
    end
    // Accepted on this edge
    @(posedge nclk);
    in_valid[r.path] <= 1'b0;
    @(negedge nclk);
    if (valid_vec !== (4'b0001 << r.path)) begin
      errors++;
      $display("row %0d: output valids are %b, expected a pulse on path %0d only",
               idx, valid_vec, r.path);
    end
    got = out_word(r.path);
    if (got !== r.expect_word) begin
      report_mismatch(out_name(r.path), got, r.expect_word);
    end
    @(posedge nclk);
    credit[r.path] <= 1'b1;
    @(posedge nclk);
    credit[r.path] <= 1'b0;
  endtask

  // Withhold send-queue credits, then hand them back one at a time
  task automatic credit_test();
    int accepts;
    accepts = 0;
    @(posedge nclk);
    in_valid[PATH_SQ] <= 1'b1;
    @(negedge nclk);
    while (ready_vec[PATH_SQ] && accepts <= CREDITS_MAX) begin
      accepts++;
      @(negedge nclk);
    end
    if (accepts != CREDITS_MAX) begin
      errors++;
      $display("send queue ready fell after %0d accepts instead of %0d", accepts, CREDITS_MAX);
    end
    if (ready_vec[N_PATHS-1:1] !== '1) begin
      errors++;
      $display("other paths lost ready while send queue credits were withheld");
    end
    @(posedge nclk);
    in_valid[PATH_SQ] <= 1'b0;
    credit[PATH_SQ]   <= 1'b1;
    @(negedge nclk);
    if (ready_vec[PATH_SQ] !== 1'b0) begin
      errors++;
      $display("send queue ready rose before the credit pulse was taken");
    end
    @(posedge nclk);
    credit[PATH_SQ] <= 1'b0;
    @(negedge nclk);
    if (ready_vec[PATH_SQ] !== 1'b1) begin
      errors++;
      $display("send queue ready did not return in the cycle after a credit pulse");
    end
    @(posedge nclk);
    credit[PATH_SQ] <= 1'b1;
    repeat (CREDITS_MAX - 1) @(posedge nclk);
    credit[PATH_SQ] <= 1'b0;
  endtask

  always @(posedge nclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    errors       = 0;
    rng          = SEED;
    in_valid     = '0;
    credit       = '0;
    user_sq      = '0;
    stack_ack    = '0;
    stack_rd_cmd = '0;
    stack_wr_cmd = '0;
    build_table();
    @(posedge rst_n);
    @(negedge nclk);
    if (valid_vec !== '0 || ready_vec !== '1) begin
      errors++;
      $display("after reset valids are %b and readies %b", valid_vec, ready_vec);
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(table_rows[i], i);
    end
    credit_test();
    @(negedge nclk);
    if (ready_vec !== '1) begin
      errors++;
      $display("not all paths ready once every credit was returned");
    end
    repeat (2) @(posedge nclk);
    $display("run finished with %0d errors and %0d assertion failures",
             errors, DUT.u_chk.fail_cnt);
    if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/rdma_credit_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_credit_chk (
  input logic                               nclk,
  input logic                               rst_n,
  input logic [rdma_stack_pkg::N_PATHS-1:0]
              [rdma_stack_pkg::CREDIT_CNT_BITS-1:0] credit_cnt,
  input logic [rdma_stack_pkg::N_PATHS-1:0] accept,
  input logic [rdma_stack_pkg::N_PATHS-1:0] credit_ret,
  input logic [rdma_stack_pkg::N_PATHS-1:0] out_valid
);

  import rdma_stack_pkg::*;

  // Count of assertion failures
  int fail_cnt = 0;

  // Items handed downstream and not yet credited back, per path
  logic [N_PATHS-1:0][CREDIT_CNT_BITS-1:0] in_flight;

  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      for (int i = 0; i < N_PATHS; i++) begin
        in_flight[i] <= in_flight[i] + accept[i] - credit_ret[i];
      end
    end
  end

  genvar p;
  generate
    for (p = 0; p < N_PATHS; p++) begin : g_path

      // Count never exceeds the slots still free downstream
      a_cnt_bound: assert property (@(posedge nclk) disable iff (!rst_n)
        credit_cnt[p] <= CREDITS_MAX - in_flight[p])
        else begin
          fail_cnt++;
          $error("credit count %0d above the %0d free slots on path %0d",
                 credit_cnt[p], CREDITS_MAX - in_flight[p], p);
        end

      // An output pulse follows an accept one cycle earlier
      a_valid_after_accept: assert property (@(posedge nclk) disable iff (!rst_n)
        out_valid[p] |-> $past(accept[p]))
        else begin
          fail_cnt++;
          $error("output valid without a prior accept on path %0d", p);
        end

      a_no_accept_empty: assert property (@(posedge nclk) disable iff (!rst_n)
        accept[p] |-> (in_flight[p] < CREDITS_MAX))
        else begin
          fail_cnt++;
          $error("accept with no free downstream slot on path %0d", p);
        end

    end
  endgenerate

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 10
) (
  output logic nclk,
  output logic rst_n
);

  initial begin
    nclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) nclk = ~nclk;
    end
  end

  // Reset released on a rising edge after RST_CYCLES cycles
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge nclk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/rdma_cmd_adapter.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_cmd_adapter (
  input  logic                           nclk,
  input  logic                           rst_n,

  // Send queue, user to core
  input  rdma_user_pkg::user_sq_t        user_sq,
  input  logic                           user_sq_valid,
  output logic                           user_sq_ready,
  output rdma_stack_pkg::rdma_sq_word_t  stack_sq,
  output logic                           stack_sq_valid,
  input  logic                           stack_sq_credit,

  // Ack, core to user
  input  rdma_stack_pkg::rdma_ack_word_t stack_ack,
  input  logic                           stack_ack_valid,
  output logic                           stack_ack_ready,
  output rdma_user_pkg::user_ack_t       user_ack,
  output logic                           user_ack_valid,
  input  logic                           user_ack_credit,

  // Memory read commands
  input  rdma_stack_pkg::rdma_mem_cmd_u  stack_rd_cmd,
  input  logic                           stack_rd_valid,
  output logic                           stack_rd_ready,
  output rdma_user_pkg::mem_req_t        mem_rd_req,
  output logic                           mem_rd_valid,
  input  logic                           mem_rd_credit,

  // Memory write commands
  input  rdma_stack_pkg::rdma_mem_cmd_u  stack_wr_cmd,
  input  logic                           stack_wr_valid,
  output logic                           stack_wr_ready,
  output rdma_user_pkg::mem_req_t        mem_wr_req,
  output logic                           mem_wr_valid,
  input  logic                           mem_wr_credit
);

  import rdma_stack_pkg::*;

  logic [N_PATHS-1:0] accept;
  logic [N_PATHS-1:0] credit_ret;
  logic [N_PATHS-1:0] ready;

  assign user_sq_ready   = ready[PATH_SQ];
  assign stack_ack_ready = ready[PATH_ACK];
  assign stack_rd_ready  = ready[PATH_RD];
  assign stack_wr_ready  = ready[PATH_WR];

  // Fire terms per path
  assign accept[PATH_SQ]  = user_sq_valid & ready[PATH_SQ];
  assign accept[PATH_ACK] = stack_ack_valid & ready[PATH_ACK];
  assign accept[PATH_RD]  = stack_rd_valid & ready[PATH_RD];
  assign accept[PATH_WR]  = stack_wr_valid & ready[PATH_WR];

  assign credit_ret[PATH_SQ]  = stack_sq_credit;
  assign credit_ret[PATH_ACK] = user_ack_credit;
  assign credit_ret[PATH_RD]  = mem_rd_credit;
  assign credit_ret[PATH_WR]  = mem_wr_credit;

  rdma_credit_ctrl u_credit (
    .nclk       (nclk),
    .rst_n      (rst_n),
    .accept     (accept),
    .credit_ret (credit_ret),
    .ready      (ready)
  );

  rdma_sq_packer u_sq_pack (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .req       (user_sq),
    .req_fire  (accept[PATH_SQ]),
    .cmd       (stack_sq),
    .cmd_valid (stack_sq_valid)
  );

  rdma_ack_unpacker u_ack_unpack (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .word      (stack_ack),
    .word_fire (accept[PATH_ACK]),
    .ack       (user_ack),
    .ack_valid (user_ack_valid)
  );

  rdma_mem_cmd_unpacker u_rd_unpack (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .cmd       (stack_rd_cmd),
    .cmd_fire  (accept[PATH_RD]),
    .req       (mem_rd_req),
    .req_valid (mem_rd_valid)
  );

  rdma_mem_cmd_unpacker u_wr_unpack (
    .nclk      (nclk),
    .rst_n     (rst_n),
    .cmd       (stack_wr_cmd),
    .cmd_fire  (accept[PATH_WR]),
    .req       (mem_wr_req),
    .req_valid (mem_wr_valid)
  );

endmodule

`default_nettype wire

// ==== source/rdma_mem_cmd_unpacker.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_mem_cmd_unpacker (
  input  logic                          nclk,
  input  logic                          rst_n,
  input  rdma_stack_pkg::rdma_mem_cmd_u cmd,
  input  logic                          cmd_fire,
  output rdma_user_pkg::mem_req_t       req,
  output logic                          req_valid
);

  import rdma_user_pkg::*;

  mem_req_t req_d;

  always_comb begin
    req_d.opcode = cmd.fld.opcode;
    // Core-issued transfers are raw and serve the local side
    req_d.mode   = MODE_RAW;
    req_d.rdma   = 1'b1;
    req_d.remote = 1'b0;
    req_d.pid    = cmd.fld.pid;
    req_d.vfid   = cmd.fld.vfid;
    req_d.last   = cmd.fld.last;
    req_d.vaddr  = cmd.fld.vaddr;
    req_d.dest   = cmd.fld.dest;
    req_d.strm   = cmd.fld.strm;
    req_d.len    = cmd.fld.len;
    req_d.actv   = cmd.fld.actv;
    req_d.host   = cmd.fld.host;
    req_d.offs   = cmd.fld.offs;
  end

  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cmd_fire;
    end
  end

  always_ff @(posedge nclk) begin
    if (cmd_fire) begin
      req <= req_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/rdma_ack_unpacker.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_ack_unpacker (
  input  logic                           nclk,
  input  logic                           rst_n,
  input  rdma_stack_pkg::rdma_ack_word_t word,
  input  logic                           word_fire,
  output rdma_user_pkg::user_ack_t       ack,
  output logic                           ack_valid
);

  import rdma_user_pkg::*;

  user_ack_t ack_d;

  always_comb begin
    ack_d.opcode = word.opcode;
    // Acks from the core always refer to remote operations
    ack_d.remote = 1'b1;
    ack_d.pid    = word.pid;
    ack_d.vfid   = word.vfid;
    ack_d.host   = word.host;
    ack_d.dest   = word.dest;
    ack_d.strm   = word.strm;
    ack_d.rsrvd  = '0;
    ack_d.last   = word.last;
  end

  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      ack_valid <= 1'b0;
    end else begin
      ack_valid <= word_fire;
    end
  end

  always_ff @(posedge nclk) begin
    if (word_fire) begin
      ack <= ack_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/rdma_sq_packer.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_sq_packer (
  input  logic                          nclk,
  input  logic                          rst_n,
  input  rdma_user_pkg::user_sq_t       req,
  input  logic                          req_fire,
  output rdma_stack_pkg::rdma_sq_word_t cmd,
  output logic                          cmd_valid
);

  import rdma_stack_pkg::*;

  rdma_sq_word_t cmd_d;

  always_comb begin
    // Reserved lanes stay zero
    cmd_d         = '0;
    cmd_d.opcode  = req.req_1.opcode;
    cmd_d.pid     = req.req_1.pid;
    cmd_d.vfid    = req.req_1.vfid;
    cmd_d.host    = req.req_1.host;
    cmd_d.last    = req.req_1.last;
    cmd_d.offs    = req.req_1.offs;
    cmd_d.vaddr_1 = req.req_1.vaddr;

    // Second address lane mixes both halves
    cmd_d.vaddr_2 = req.req_2.vaddr;
    cmd_d.dest    = req.req_1.dest;
    cmd_d.strm    = req.req_2.strm;

    cmd_d.len     = {{(RDMA_LEN_BITS-LEN_BITS){1'b0}}, req.req_1.len};

    // Immediate carries the second half's offset and length
    cmd_d.imm_offs = req.req_2.offs[SQ_IMM_OFFS_BITS-1:0];
    cmd_d.imm_len  = req.req_2.len;
  end

  always_ff @(posedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= req_fire;
    end
  end

  always_ff @(posedge nclk) begin
    if (req_fire) begin
      cmd <= cmd_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/rdma_credit_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module rdma_credit_ctrl (
  input  logic                               nclk,
  input  logic                               rst_n,
  input  logic [rdma_stack_pkg::N_PATHS-1:0] accept,
  input  logic [rdma_stack_pkg::N_PATHS-1:0] credit_ret,
  output logic [rdma_stack_pkg::N_PATHS-1:0] ready
);

  import rdma_stack_pkg::*;

  localparam logic [CREDIT_CNT_BITS-1:0] CNT_FULL = CREDIT_CNT_BITS'(CREDITS_MAX);

  // One counter per output path
  logic [N_PATHS-1:0][CREDIT_CNT_BITS-1:0] credit_cnt;

  genvar p;
  generate
    for (p = 0; p < N_PATHS; p++) begin : g_path

      always_ff @(posedge nclk or negedge rst_n) begin
        if (!rst_n) begin
          credit_cnt[p] <= CNT_FULL;
        end else begin
          case ({accept[p], credit_ret[p]})
            // Item sent downstream, one credit consumed
            2'b10: begin
              if (credit_cnt[p] != '0) begin
                credit_cnt[p] <= credit_cnt[p] - 1'b1;
              end
            end
            // Receiver freed a slot
            2'b01: begin
              if (credit_cnt[p] != CNT_FULL) begin
                credit_cnt[p] <= credit_cnt[p] + 1'b1;
              end
            end
            // Both or neither, count holds
            default: begin
              credit_cnt[p] <= credit_cnt[p];
            end
          endcase
        end
      end

      // Input may only be taken while a downstream slot is known free
      assign ready[p] = (credit_cnt[p] != '0);

    end
  endgenerate

endmodule

`default_nettype wire

// ==== source/rdma_user_pkg.sv ====
`default_nettype none

package rdma_user_pkg;

  import rdma_stack_pkg::*;

  // Memory transfer modes
  localparam logic MODE_RAW = 1'b0;

  localparam int USER_ACK_RSRVD_BITS = 32 - (OPCODE_BITS + 1 + PID_BITS + DEST_BITS + 1
                                             + DEST_BITS + STRM_BITS + 1);

  // One half of a send-queue request
  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic [PID_BITS-1:0]    pid;
    logic [DEST_BITS-1:0]   vfid;
    logic                   host;
    logic                   last;
    logic [OFFS_BITS-1:0]   offs;
    logic [VADDR_BITS-1:0]  vaddr;
    logic [DEST_BITS-1:0]   dest;
    logic [STRM_BITS-1:0]   strm;
    logic [LEN_BITS-1:0]    len;
  } user_req_t;

  typedef struct packed {
    user_req_t req_1;
    user_req_t req_2;
  } user_sq_t;

  typedef struct packed {
    logic [OPCODE_BITS-1:0]         opcode;
    logic                           remote;
    logic [PID_BITS-1:0]            pid;
    logic [DEST_BITS-1:0]           vfid;
    logic                           host;
    logic [DEST_BITS-1:0]           dest;
    logic [STRM_BITS-1:0]           strm;
    logic [USER_ACK_RSRVD_BITS-1:0] rsrvd;
    logic                           last;
  } user_ack_t;

  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic                   mode;
    logic                   rdma;
    logic                   remote;
    logic [PID_BITS-1:0]    pid;
    logic [DEST_BITS-1:0]   vfid;
    logic                   last;
    logic [VADDR_BITS-1:0]  vaddr;
    logic [DEST_BITS-1:0]   dest;
    logic [STRM_BITS-1:0]   strm;
    logic [LEN_BITS-1:0]    len;
    logic                   actv;
    logic                   host;
    logic [OFFS_BITS-1:0]   offs;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== source/rdma_stack_pkg.sv ====
`default_nettype none

package rdma_stack_pkg;

  // User-side field widths
  localparam int OPCODE_BITS = 5;
  localparam int PID_BITS    = 6;
  localparam int DEST_BITS   = 4;
  localparam int STRM_BITS   = 2;
  localparam int OFFS_BITS   = 6;
  localparam int VADDR_BITS  = 48;
  localparam int LEN_BITS    = 28;

  // Core word field widths
  localparam int RDMA_QPN_BITS   = 24;
  localparam int RDMA_VADDR_BITS = 64;
  localparam int RDMA_LEN_BITS   = 32;
  localparam int RDMA_IMM_BITS   = 32;

  // Opcode sits alone in the low 32-bit lane of every core word
  localparam int OP_LANE_BITS   = 32;
  localparam int OP_RSVD_BITS   = OP_LANE_BITS - OPCODE_BITS;
  localparam int QPN_RSVD_BITS  = RDMA_QPN_BITS - DEST_BITS - PID_BITS;
  localparam int SQ_ADDR1_RSVD  = RDMA_VADDR_BITS - VADDR_BITS;
  localparam int SQ_ADDR2_RSVD  = RDMA_VADDR_BITS - VADDR_BITS - DEST_BITS - STRM_BITS;
  localparam int SQ_IMM_OFFS_BITS = RDMA_IMM_BITS - LEN_BITS;

  localparam int RDMA_ACK_BITS  = 96;
  localparam int ACK_USED_BITS  = OP_LANE_BITS + RDMA_QPN_BITS + 1 + DEST_BITS + STRM_BITS + 1;

  localparam int RDMA_MEM_CMD_BITS = 160;
  localparam int MEM_CMD_USED_BITS = OP_LANE_BITS + RDMA_QPN_BITS + 1 + VADDR_BITS + DEST_BITS
                                     + STRM_BITS + LEN_BITS + 1 + 1 + OFFS_BITS;

  // Credits per output path
  localparam int CREDITS_MAX     = 4;
  localparam int CREDIT_CNT_BITS = $clog2(CREDITS_MAX + 1);

  localparam int PATH_SQ  = 0;
  localparam int PATH_ACK = 1;
  localparam int PATH_RD  = 2;
  localparam int PATH_WR  = 3;
  localparam int N_PATHS  = 4;

  // Send-queue command, 256 bits
  typedef struct packed {
    logic [SQ_IMM_OFFS_BITS-1:0] imm_offs;
    logic [LEN_BITS-1:0]         imm_len;
    logic [RDMA_LEN_BITS-1:0]    len;
    logic [SQ_ADDR2_RSVD-1:0]    rsvd_addr_2;
    logic [STRM_BITS-1:0]        strm;
    logic [DEST_BITS-1:0]        dest;
    logic [VADDR_BITS-1:0]       vaddr_2;
    logic [SQ_ADDR1_RSVD-1:0]    rsvd_addr_1;
    logic [VADDR_BITS-1:0]       vaddr_1;
    logic [OFFS_BITS-1:0]        offs;
    logic                        last;
    logic                        host;
    logic [QPN_RSVD_BITS-1:0]    rsvd_qpn;
    logic [DEST_BITS-1:0]        vfid;
    logic [PID_BITS-1:0]         pid;
    logic [OP_RSVD_BITS-1:0]     rsvd_op;
    logic [OPCODE_BITS-1:0]      opcode;
  } rdma_sq_word_t;

  typedef struct packed {
    logic [RDMA_ACK_BITS-ACK_USED_BITS-1:0] rsvd_top;
    logic                     last;
    logic [STRM_BITS-1:0]     strm;
    logic [DEST_BITS-1:0]     dest;
    logic                     host;
    logic [QPN_RSVD_BITS-1:0] rsvd_qpn;
    logic [DEST_BITS-1:0]     vfid;
    logic [PID_BITS-1:0]      pid;
    logic [OP_RSVD_BITS-1:0]  rsvd_op;
    logic [OPCODE_BITS-1:0]   opcode;
  } rdma_ack_word_t;

  typedef struct packed {
    logic [RDMA_MEM_CMD_BITS-MEM_CMD_USED_BITS-1:0] rsvd_top;
    logic [OFFS_BITS-1:0]     offs;
    logic                     host;
    logic                     actv;
    logic [LEN_BITS-1:0]      len;
    logic [STRM_BITS-1:0]     strm;
    logic [DEST_BITS-1:0]     dest;
    logic [VADDR_BITS-1:0]    vaddr;
    logic                     last;
    logic [QPN_RSVD_BITS-1:0] rsvd_qpn;
    logic [DEST_BITS-1:0]     vfid;
    logic [PID_BITS-1:0]      pid;
    logic [OP_RSVD_BITS-1:0]  rsvd_op;
    logic [OPCODE_BITS-1:0]   opcode;
  } rdma_mem_cmd_fields_t;

  // Memory command as raw core bits or as decoded fields
  typedef union packed {
    logic [RDMA_MEM_CMD_BITS-1:0] raw;
    rdma_mem_cmd_fields_t         fld;
  } rdma_mem_cmd_u;

endpackage

`default_nettype wire
